/* common/calc_pkg.sv */
`default_nettype none

package calc_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int DIGIT_W = 4;    // one bcd digit
    localparam int STATE_W = 3;    // calculator state code
    localparam int ADDR_W  = 4;    // apb address bits

    //////////////////////////////////////////////////
    // calculator states
    //////////////////////////////////////////////////
    // any other code shows all blanks
    localparam logic [STATE_W-1:0] ST_LEFT   = 3'd0;  // left operand entry
    localparam logic [STATE_W-1:0] ST_OP     = 3'd1;  // operator chosen
    localparam logic [STATE_W-1:0] ST_RIGHT  = 3'd2;  // right operand entry
    localparam logic [STATE_W-1:0] ST_RESULT = 3'd3;  // answer on display

    // key codes above the digits 0 to 9
    localparam logic [DIGIT_W-1:0] KEY_ADD = 4'd10;
    localparam logic [DIGIT_W-1:0] KEY_SUB = 4'd11;
    localparam logic [DIGIT_W-1:0] KEY_EQ  = 4'd12;
    localparam logic [DIGIT_W-1:0] KEY_CLR = 4'd13;   // highest legal key

    // digit values with a special picture
    localparam logic [DIGIT_W-1:0] BLANK_CODE = 4'd15;  // dark digit
    localparam logic [DIGIT_W-1:0] MINUS_CODE = 4'd10;  // segment g only

    //////////////////////////////////////////////////
    // apb register map
    //////////////////////////////////////////////////
    localparam logic [ADDR_W-1:0] ADDR_KEY  = 4'h0;   // write only, key in bits 3:0
    // read only
    // digit 3 in 3:0, digit 2 in 7:4, digit 1 in 11:8, state in 14:12
    localparam logic [ADDR_W-1:0] ADDR_DISP = 4'h4;

endpackage

`default_nettype wire

/* common/digit_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface digit_bus_if;

    logic [calc_pkg::STATE_W-1:0] state;        // calculator state
    logic [calc_pkg::DIGIT_W-1:0] left_tens;    // left operand
    logic [calc_pkg::DIGIT_W-1:0] left_unit;
    logic [calc_pkg::DIGIT_W-1:0] right_tens;   // right operand
    logic [calc_pkg::DIGIT_W-1:0] right_unit;
    logic                         op_sub;       // 1 subtract, 0 add
    logic [calc_pkg::DIGIT_W-1:0] ans_hund;     // answer, already blanked
    logic [calc_pkg::DIGIT_W-1:0] ans_tens;
    logic [calc_pkg::DIGIT_W-1:0] ans_unit;

    // entry stage owns state and operands
    modport entry_mp (output state, left_tens, left_unit, right_tens, right_unit,
                      op_sub);

    modport alu_mp (input left_tens, left_unit, right_tens, right_unit, op_sub,
                    output ans_hund, ans_tens, ans_unit);

    modport disp_mp (input state, left_tens, left_unit, right_tens, right_unit,
                     ans_hund, ans_tens, ans_unit);

endinterface

`default_nettype wire

/* design/key_apb_port.sv */
`timescale 1ns/100ps
`default_nettype none

module key_apb_port
(
    input  wire                            clk,
    input  wire                            arst_n,
    // apb slave
    input  wire                            psel,
    input  wire                            penable,
    input  wire                            pwrite,
    input  wire  [calc_pkg::ADDR_W-1:0]    paddr,
    input  wire  [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    // key pulse to entry
    output logic                           key_valid,
    output logic [calc_pkg::DIGIT_W-1:0]   key_code,
    // readback sources
    input  wire  [3*calc_pkg::DIGIT_W-1:0] disp_digits,  // digit 1 in the top nibble
    input  wire  [calc_pkg::STATE_W-1:0]   state
);

    localparam int PAD_W = 32 - calc_pkg::STATE_W - 3 * calc_pkg::DIGIT_W;

    logic access;   // access phase
    logic wr_key;   // legal key write
    logic rd_disp;  // legal display read

    assign access  = psel && penable;
    assign wr_key  = access && pwrite && (paddr == calc_pkg::ADDR_KEY);
    assign rd_disp = access && !pwrite && (paddr == calc_pkg::ADDR_DISP);

    assign pready  = 1'b1;                           // never waits
    assign pslverr = access && !(wr_key || rd_disp); // wrong direction or no register

    // readback word
    assign prdata = rd_disp ? {{PAD_W{1'b0}}, state, disp_digits} : 32'd0;

    //////////////////////////////////////////////////
    // key pulse, one cycle after the write completes
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            key_valid <= 1'b0;
        else
            key_valid <= wr_key && (pwdata[3:0] <= calc_pkg::KEY_CLR);  // drop 14, 15
    end

    always_ff @(posedge clk)
    begin
        if (wr_key)
            key_code <= pwdata[calc_pkg::DIGIT_W-1:0];
    end

endmodule

`default_nettype wire

/* entry/calc_entry.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_entry
(
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          key_valid,   // one key per pulse
    input  wire [calc_pkg::DIGIT_W-1:0]  key_code,
    digit_bus_if.entry_mp                bus
);

    logic is_digit;   // codes 0 to 9
    logic is_op;      // add or subtract

    assign is_digit = (key_code <= 4'd9);
    assign is_op    = (key_code == calc_pkg::KEY_ADD) || (key_code == calc_pkg::KEY_SUB);

    //////////////////////////////////////////////////
    // entry fsm
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bus.state      <= calc_pkg::ST_LEFT;
            bus.left_tens  <= '0;
            bus.left_unit  <= '0;
            bus.right_tens <= '0;
            bus.right_unit <= '0;
            bus.op_sub     <= 1'b0;
        end
        else if (key_valid)
        begin
            if (key_code == calc_pkg::KEY_CLR)
            begin
                // back to power up values
                bus.state      <= calc_pkg::ST_LEFT;
                bus.left_tens  <= '0;
                bus.left_unit  <= '0;
                bus.right_tens <= '0;
                bus.right_unit <= '0;
                bus.op_sub     <= 1'b0;
            end
            else if (is_digit)
            begin
                case (bus.state)
                    calc_pkg::ST_LEFT:
                    begin
                        bus.left_tens <= bus.left_unit;   // unit moves up
                        bus.left_unit <= key_code;
                    end
                    calc_pkg::ST_OP:
                    begin
                        bus.right_tens <= '0;             // right operand starts empty
                        bus.right_unit <= key_code;
                        bus.state      <= calc_pkg::ST_RIGHT;
                    end
                    calc_pkg::ST_RIGHT:
                    begin
                        bus.right_tens <= bus.right_unit;
                        bus.right_unit <= key_code;
                    end
                    calc_pkg::ST_RESULT:
                    begin
                        // new calculation
                        bus.state      <= calc_pkg::ST_LEFT;
                        bus.left_tens  <= '0;
                        bus.left_unit  <= key_code;
                        bus.right_tens <= '0;
                        bus.right_unit <= '0;
                        bus.op_sub     <= 1'b0;
                    end
                    default: ;
                endcase
            end
            else if (is_op && (bus.state != calc_pkg::ST_RESULT))
            begin
                bus.op_sub <= (key_code == calc_pkg::KEY_SUB);  // last operator wins
                if (bus.state == calc_pkg::ST_LEFT)
                    bus.state <= calc_pkg::ST_OP;
            end
            else if ((key_code == calc_pkg::KEY_EQ) && (bus.state == calc_pkg::ST_RIGHT))
                bus.state <= calc_pkg::ST_RESULT;
            // anything else is ignored
        end
    end

endmodule

`default_nettype wire

/* design/calc_alu_bcd.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_alu_bcd
(
    input  wire           clk,
    input  wire           arst_n,
    digit_bus_if.alu_mp   bus
);

    // two bcd digits to binary, 99 at most
    function automatic logic [6:0] to_bin(input logic [calc_pkg::DIGIT_W-1:0] tens,
                                          input logic [calc_pkg::DIGIT_W-1:0] unit);
        return 7'(tens) * 7'd10 + 7'(unit);
    endfunction

    // double dabble, 8 bit binary to hund, tens, unit
    function automatic logic [11:0] bin2bcd(input logic [7:0] bin);
        logic [19:0] sh;
        sh = {12'd0, bin};
        for (int i = 0; i < 8; i++)
        begin
            for (int j = 0; j < 3; j++)
            begin
                if (sh[8+4*j +: 4] >= 4'd5)
                    sh[8+4*j +: 4] = sh[8+4*j +: 4] + 4'd3;   // add 3 before shift
            end
            sh = sh << 1;
        end
        return sh[19:8];
    endfunction

    logic [6:0]                   left_bin;
    logic [6:0]                   right_bin;
    logic                         neg;      // subtract with larger right operand
    logic [7:0]                   mag;      // 198 at most
    logic [11:0]                  bcd;
    logic [calc_pkg::DIGIT_W-1:0] hund_d;   // after sign and blanking
    logic [calc_pkg::DIGIT_W-1:0] tens_d;

    assign left_bin  = to_bin(bus.left_tens, bus.left_unit);
    assign right_bin = to_bin(bus.right_tens, bus.right_unit);
    assign neg       = bus.op_sub && (right_bin > left_bin);

    always_comb
    begin
        if (!bus.op_sub)
            mag = {1'b0, left_bin} + {1'b0, right_bin};
        else if (neg)
            mag = {1'b0, right_bin - left_bin};   // magnitude only
        else
            mag = {1'b0, left_bin - right_bin};
    end

    assign bcd = bin2bcd(mag);

    //////////////////////////////////////////////////
    // sign and leading zero blanking
    //////////////////////////////////////////////////
    always_comb
    begin
        if (neg)
            hund_d = calc_pkg::MINUS_CODE;
        else if (bcd[11:8] == 4'd0)
            hund_d = calc_pkg::BLANK_CODE;
        else
            hund_d = bcd[11:8];
        // tens zero goes dark without a real hundreds digit
        if ((hund_d > 4'd9) && (bcd[7:4] == 4'd0))
            tens_d = calc_pkg::BLANK_CODE;
        else
            tens_d = bcd[7:4];
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bus.ans_hund <= calc_pkg::BLANK_CODE;
            bus.ans_tens <= calc_pkg::BLANK_CODE;
            bus.ans_unit <= calc_pkg::BLANK_CODE;
        end
        else
        begin
            bus.ans_hund <= hund_d;
            bus.ans_tens <= tens_d;
            bus.ans_unit <= bcd[3:0];   // unit always shown
        end
    end

endmodule

`default_nettype wire

/* design/display_ctl.sv */
`timescale 1ns/100ps
`default_nettype none

module display_ctl
(
    digit_bus_if.disp_mp                 bus,
    output logic [calc_pkg::DIGIT_W-1:0] bcd_out1,   // leftmost digit
    output logic [calc_pkg::DIGIT_W-1:0] bcd_out2,
    output logic [calc_pkg::DIGIT_W-1:0] bcd_out3    // rightmost digit
);

    // zero in an operand tens place stays dark
    function automatic logic [calc_pkg::DIGIT_W-1:0] blank_zero(
        input logic [calc_pkg::DIGIT_W-1:0] tens);
        return (tens == '0) ? calc_pkg::BLANK_CODE : tens;
    endfunction

    logic [calc_pkg::DIGIT_W-1:0] left_tens_b;
    logic [calc_pkg::DIGIT_W-1:0] right_tens_b;

    assign left_tens_b  = blank_zero(bus.left_tens);
    assign right_tens_b = blank_zero(bus.right_tens);

    // digit select by state
    always_comb
    begin
        case (bus.state)
            calc_pkg::ST_LEFT:
            begin
                bcd_out1 = calc_pkg::BLANK_CODE;
                bcd_out2 = left_tens_b;
                bcd_out3 = bus.left_unit;
            end
            calc_pkg::ST_OP, calc_pkg::ST_RIGHT:
            begin
                bcd_out1 = calc_pkg::BLANK_CODE;
                bcd_out2 = right_tens_b;     // empty right operand in ST_OP
                bcd_out3 = bus.right_unit;
            end
            calc_pkg::ST_RESULT:
            begin
                bcd_out1 = bus.ans_hund;     // blanked in the alu
                bcd_out2 = bus.ans_tens;
                bcd_out3 = bus.ans_unit;
            end
            default:
            begin
                bcd_out1 = calc_pkg::BLANK_CODE;
                bcd_out2 = calc_pkg::BLANK_CODE;
                bcd_out3 = calc_pkg::BLANK_CODE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/seg_scan.sv */
`timescale 1ns/100ps
`default_nettype none

module seg_scan
#(
    parameter int SCAN_DIV = 4    // cycles per digit slot
)
(
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire [calc_pkg::DIGIT_W-1:0]  bcd_out1,   // on dig_en[0]
    input  wire [calc_pkg::DIGIT_W-1:0]  bcd_out2,   // on dig_en[1]
    input  wire [calc_pkg::DIGIT_W-1:0]  bcd_out3,   // on dig_en[2]
    output logic [6:0]                   seg,        // {g,f,e,d,c,b,a}, active high
    output logic [2:0]                   dig_en
);

    localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    // segment table
    function automatic logic [6:0] seg_of(input logic [calc_pkg::DIGIT_W-1:0] code);
        case (code)
            4'd0:    return 7'b0111111;
            4'd1:    return 7'b0000110;
            4'd2:    return 7'b1011011;
            4'd3:    return 7'b1001111;
            4'd4:    return 7'b1100110;
            4'd5:    return 7'b1101101;
            4'd6:    return 7'b1111101;
            4'd7:    return 7'b0000111;
            4'd8:    return 7'b1111111;
            4'd9:    return 7'b1101111;
            calc_pkg::MINUS_CODE: return 7'b1000000;
            default: return 7'b0000000;   // blank, 11 to 14 dark too
        endcase
    endfunction

    logic [CNT_W-1:0]             div_cnt;
    logic                         tick;       // last cycle of a slot
    logic [2:0]                   en_nxt;
    logic [calc_pkg::DIGIT_W-1:0] cur_digit;  // digit for the next enable

    assign tick = (div_cnt == CNT_W'(SCAN_DIV - 1));

    always_comb
    begin
        if (!tick)
            en_nxt = dig_en;
        else if (dig_en[2] || (dig_en == 3'b000))
            en_nxt = 3'b001;                 // first tick or wrap
        else
            en_nxt = dig_en << 1;
        case (en_nxt)
            3'b001:  cur_digit = bcd_out1;
            3'b010:  cur_digit = bcd_out2;
            3'b100:  cur_digit = bcd_out3;
            default: cur_digit = calc_pkg::BLANK_CODE;   // still idle
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt <= '0;
            dig_en  <= 3'b000;
            seg     <= 7'b0000000;
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            dig_en  <= en_nxt;
            seg     <= seg_of(cur_digit);    // tracks digit changes inside a slot
        end
    end

endmodule

`default_nettype wire

/* design/calc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_top
#(
    parameter int SCAN_DIV = 50000    // clocks per shown digit
)
(
    input  wire                          clk,
    input  wire                          arst_n,
    // apb slave
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire  [calc_pkg::ADDR_W-1:0]  paddr,
    input  wire  [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    // seven segment display
    output logic [6:0]                   seg,
    output logic [2:0]                   dig_en
);

    digit_bus_if bus ();    // stage to stage digits

    logic                         key_valid;
    logic [calc_pkg::DIGIT_W-1:0] key_code;
    logic [calc_pkg::DIGIT_W-1:0] bcd_out1;   // shown digits, left to right
    logic [calc_pkg::DIGIT_W-1:0] bcd_out2;
    logic [calc_pkg::DIGIT_W-1:0] bcd_out3;

    key_apb_port i_apb
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .disp_digits ({bcd_out1, bcd_out2, bcd_out3}),
        .state       (bus.state)
    );

    calc_entry i_entry
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .key_valid (key_valid),
        .key_code  (key_code),
        .bus       (bus.entry_mp)
    );

    calc_alu_bcd i_alu
    (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (bus.alu_mp)
    );

    display_ctl i_disp
    (
        .bus      (bus.disp_mp),
        .bcd_out1 (bcd_out1),
        .bcd_out2 (bcd_out2),
        .bcd_out3 (bcd_out3)
    );

    seg_scan #(.SCAN_DIV(SCAN_DIV)) i_scan
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .bcd_out1 (bcd_out1),
        .bcd_out2 (bcd_out2),
        .bcd_out3 (bcd_out3),
        .seg      (seg),
        .dig_en   (dig_en)
    );

endmodule

`default_nettype wire

/* bench/calc_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_checker
(
    input wire        clk,
    input wire        arst_n,
    input wire        psel,
    input wire        penable,
    input wire        pwrite,
    input wire [3:0]  paddr,
    input wire [31:0] pwdata,
    input wire [31:0] prdata,
    input wire        pready,
    input wire        pslverr,
    input wire [6:0]  seg,
    input wire [2:0]  dig_en
);

    logic [3:0]  key_hist [0:1023];    // every key seen on the bus
    int          key_cnt = 0;
    string       test_name = "none";
    int          t_checks = 0;         // current test
    int          t_errs   = 0;
    int          n_pass   = 0;         // whole run
    int          n_errs   = 0;
    logic        legal;
    logic [31:0] exp_word;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    // replay keys from reset and build the expected readback word
    function automatic logic [31:0] expected_word(input int n);
        logic [2:0] st;
        int         a;                 // left operand value
        int         b;                 // right operand value
        int         res;
        int         mag;
        logic       sub;
        logic [3:0] k;
        logic [3:0] d1;
        logic [3:0] d2;
        logic [3:0] d3;
        st  = 3'd0;
        a   = 0;
        b   = 0;
        sub = 1'b0;
        for (int i = 0; i < n; i++)
        begin
            k = key_hist[i];
            if (k == calc_pkg::KEY_CLR)
            begin
                st  = 3'd0;
                a   = 0;
                b   = 0;
                sub = 1'b0;
            end
            else if (k <= 4'd9)
            begin
                case (st)
                    3'd0: a = (a % 10) * 10 + k;   // shift into left
                    3'd1:
                    begin
                        b  = k;                    // fresh right operand
                        st = 3'd2;
                    end
                    3'd2: b = (b % 10) * 10 + k;
                    default:
                    begin
                        st  = 3'd0;                // new calculation
                        a   = k;
                        b   = 0;
                        sub = 1'b0;
                    end
                endcase
            end
            else if ((k == calc_pkg::KEY_ADD || k == calc_pkg::KEY_SUB) && st != 3'd3)
            begin
                sub = (k == calc_pkg::KEY_SUB);
                if (st == 3'd0)
                    st = 3'd1;
            end
            else if (k == calc_pkg::KEY_EQ && st == 3'd2)
                st = 3'd3;
            // 14, 15 and out of place keys change nothing
        end
        res = sub ? a - b : a + b;
        mag = (res < 0) ? -res : res;
        d1  = calc_pkg::BLANK_CODE;
        if (st == 3'd3)
        begin
            if (res < 0)
                d1 = calc_pkg::MINUS_CODE;
            else if (mag / 100 != 0)
                d1 = mag / 100;
            d2 = (d1 > 4'd9 && (mag / 10) % 10 == 0) ? calc_pkg::BLANK_CODE : (mag / 10) % 10;
            d3 = mag % 10;
        end
        else
        begin
            mag = (st == 3'd0) ? a : b;    // operand on show
            d2  = (mag / 10 == 0) ? calc_pkg::BLANK_CODE : mag / 10;
            d3  = mag % 10;
        end
        return {17'd0, st, d1, d2, d3};
    endfunction

    // segments {g,f,e,d,c,b,a}
    function automatic logic [6:0] seg_pattern(input logic [3:0] d);
        case (d)
            4'd0:    return 7'b0111111;
            4'd1:    return 7'b0000110;
            4'd2:    return 7'b1011011;
            4'd3:    return 7'b1001111;
            4'd4:    return 7'b1100110;
            4'd5:    return 7'b1101101;
            4'd6:    return 7'b1111101;
            4'd7:    return 7'b0000111;
            4'd8:    return 7'b1111111;
            4'd9:    return 7'b1101111;
            4'd10:   return 7'b1000000;   // minus
            default: return 7'b0000000;
        endcase
    endfunction

    task automatic tally(input bit ok);
        t_checks = t_checks + 1;
        if (ok)
            n_pass = n_pass + 1;
        else
        begin
            t_errs = t_errs + 1;
            n_errs = n_errs + 1;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        t_checks  = 0;
        t_errs    = 0;
    endtask

    task automatic end_test();
        $display("%s: %0d checks, %0d errors", test_name, t_checks, t_errs);
    endtask

    task automatic report();
        $display("total: %0d checks passed, %0d errors", n_pass, n_errs);
    endtask

    //////////////////////////////////////////////////
    // apb monitor
    //////////////////////////////////////////////////
    always @(posedge clk)
    begin
        if (arst_n && psel && penable)
        begin
            legal = (pwrite && paddr == calc_pkg::ADDR_KEY) ||
                    (!pwrite && paddr == calc_pkg::ADDR_DISP);
            if (pready !== 1'b1)
                $display("Error %0t pready exp 1 got %b", $time, pready);
            tally(pready === 1'b1);
            if (pslverr !== !legal)
                $display("Error %0t pslverr exp %0b got %0b", $time, !legal, pslverr);
            tally(pslverr === !legal);
            if (legal && pwrite)
            begin
                key_hist[key_cnt] = pwdata[3:0];
                key_cnt = key_cnt + 1;
            end
            else if (legal)
            begin
                exp_word = expected_word(key_cnt);
                if (prdata !== exp_word)
                    $display("Error %0t disp_word exp %h got %h", $time, exp_word, prdata);
                tally(prdata === exp_word);
            end
        end
    end

    // watch the scanner for three slots at the falling edge
    task automatic check_scan(input int slot);
        logic [2:0]  seen;
        logic [31:0] w;
        logic [3:0]  d;
        logic [6:0]  exp_seg;
        logic [2:0]  prev_en;
        int          run_len;
        logic        first_run;
        seen      = 3'b000;
        prev_en   = 3'b000;
        run_len   = 0;
        first_run = 1'b1;
        w         = expected_word(key_cnt);
        repeat (3 * slot)
        begin
            @(negedge clk);
            d = calc_pkg::BLANK_CODE;
            case (dig_en)
                3'b001:  d = w[11:8];   // leftmost
                3'b010:  d = w[7:4];
                3'b100:  d = w[3:0];
                default: $display("dig_en %b at %0t is not one-hot", dig_en, $time);
            endcase
            seen    = seen | dig_en;
            exp_seg = seg_pattern(d);
            if (seg !== exp_seg)
                $display("Error %0t seg exp %b got %b", $time, exp_seg, seg);
            tally(seg === exp_seg && $onehot(dig_en));
            // a slot seen from start to end lasts slot cycles
            if (run_len != 0 && dig_en != prev_en)
            begin
                if (!first_run)
                begin
                    if (run_len != slot)
                        $display("Error %0t dig_en slot length exp %0d got %0d",
                                 $time, slot, run_len);
                    tally(run_len == slot);
                end
                first_run = 1'b0;
                run_len   = 0;
            end
            run_len = run_len + 1;
            prev_en = dig_en;
        end
        if (seen != 3'b111)
            $display("scan did not visit every digit, seen %b", seen);
        tally(seen == 3'b111);
    endtask

endmodule

`default_nettype wire

/* bench/calc_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_tb;

    localparam int SCAN_DIV  = 4;
    localparam int N_ADD     = 40;
    localparam int N_SUB     = 30;            // plus one zero case
    localparam int KEY_TOTAL = 2 + 1 + N_ADD * 6 + 1 + (N_SUB + 1) * 6 + 20 + 5;
    localparam int LIMIT     = KEY_TOTAL * 12 + 200;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [6:0]  seg;
    logic [2:0]  dig_en;
    logic [31:0] rand_state = 32'hce68_ee37;
    int          cycle_cnt  = 0;
    int          a;
    int          b;

    always #5 clk = ~clk;

    calc_top #(.SCAN_DIV(SCAN_DIV)) i_dut
    (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .seg(seg), .dig_en(dig_en)
    );

    calc_checker i_chk
    (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .seg(seg), .dig_en(dig_en)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    //////////////////////////////////////////////////
    // apb driver on the falling edge
    //////////////////////////////////////////////////
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;                 // setup phase
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;                 // access phase
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // key write followed by a display read once it settles
    task automatic press_key(input logic [3:0] k);
        apb_access(1'b1, calc_pkg::ADDR_KEY, {28'd0, k});
        repeat (3) @(negedge clk);
        apb_access(1'b0, calc_pkg::ADDR_DISP, 32'd0);
    endtask

    task automatic run_calc(input int x, input logic [3:0] op, input int y);
        press_key(x / 10);
        press_key(x % 10);
        press_key(op);
        press_key(y / 10);
        press_key(y % 10);
        press_key(calc_pkg::KEY_EQ);
    endtask

    // hang guard
    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= LIMIT)
        begin
            $display("timeout: tests did not finish");
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial
    begin
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 4'd0;
        pwdata  = 32'd0;
        repeat (5) @(negedge clk);
        arst_n  = 1'b1;

        i_chk.start_test("reset");
        apb_access(1'b0, calc_pkg::ADDR_DISP, 32'd0);
        i_chk.end_test();

        i_chk.start_test("left entry");
        press_key(4'd7);                // tens still dark
        press_key(4'd3);                // 7 moves to tens
        i_chk.end_test();

        i_chk.start_test("random add");
        press_key(calc_pkg::KEY_CLR);
        for (int i = 0; i < N_ADD; i++)
        begin
            rand_state = lcg_next(rand_state);
            a = (rand_state >> 16) % 100;
            rand_state = lcg_next(rand_state);
            b = (rand_state >> 16) % 100;
            run_calc(a, calc_pkg::KEY_ADD, b);
        end
        i_chk.end_test();

        i_chk.start_test("random sub");
        press_key(calc_pkg::KEY_CLR);
        for (int i = 0; i < N_SUB; i++)
        begin
            rand_state = lcg_next(rand_state);
            a = (rand_state >> 16) % 100;
            rand_state = lcg_next(rand_state);
            b = (rand_state >> 16) % 100;
            run_calc(a, calc_pkg::KEY_SUB, b);
        end
        run_calc(a, calc_pkg::KEY_SUB, a);   // zero result
        i_chk.end_test();

        i_chk.start_test("control keys");
        press_key(calc_pkg::KEY_CLR);
        press_key(4'd4);
        press_key(calc_pkg::KEY_ADD);
        press_key(calc_pkg::KEY_SUB);   // replaces add in ST_OP
        press_key(4'd7);
        press_key(calc_pkg::KEY_EQ);    // minus, dark tens, 3
        press_key(4'd1);                // fresh start after a result
        press_key(4'd2);
        press_key(calc_pkg::KEY_CLR);   // mid entry
        press_key(4'd5);
        press_key(calc_pkg::KEY_ADD);
        press_key(4'd3);
        press_key(calc_pkg::KEY_ADD);   // operator change in ST_RIGHT
        press_key(4'd6);
        press_key(calc_pkg::KEY_EQ);
        press_key(4'd8);
        press_key(4'd14);               // not a key
        press_key(calc_pkg::KEY_EQ);    // no right operand yet
        apb_access(1'b1, calc_pkg::ADDR_DISP, 32'h0000_0123);
        apb_access(1'b0, calc_pkg::ADDR_KEY, 32'd0);
        apb_access(1'b1, 4'h8, 32'd5);
        apb_access(1'b0, calc_pkg::ADDR_DISP, 32'd0);   // readback unchanged
        i_chk.end_test();

        i_chk.start_test("scan");
        run_calc(9, calc_pkg::KEY_SUB, 47);   // minus, 3, 8 on show
        i_chk.check_scan(SCAN_DIV);
        i_chk.end_test();

        i_chk.report();
        if (i_chk.n_errs == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
common/calc_pkg.sv
common/digit_bus_if.sv
design/key_apb_port.sv
entry/calc_entry.sv
design/calc_alu_bcd.sv
design/display_ctl.sv
design/seg_scan.sv
design/calc_top.sv
bench/calc_checker.sv
bench/calc_tb.sv
